/* src.f */
simd_alu_pkg.sv
apb_regs.sv
alu_ctrl_fsm.sv
div_step_counter.sv
lane_alu.sv
lane_divider.sv
simd_alu_top.sv
tb_simd_alu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_simd_alu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tb_simd_alu.sv */
module tb_simd_alu
	import simd_alu_pkg::*;
();

	localparam int ADDR_W = 8;
	localparam int POLL_LIMIT = 200;

	logic              clk;
	logic              arst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic              pready;
	logic              pslverr;

	int          n_errors;
	int          n_checks;
	int          n_tests;
	logic [31:0] lcg_state;

	lane_w_e widths[4] = '{W8, W16, W32, W64};
	alu_op_e bit_ops[5] = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_MOV};
	alu_op_e sh_ops[4] = '{OP_SLL, OP_SRL, OP_SRA, OP_RTTH};

	simd_alu_top #(
		.APB_ADDR_W(ADDR_W)
	) i_simd_alu_top (
		.clk    (clk),
		.arst_n (arst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function logic [31:0] next_rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function logic [63:0] next_rand64();
		logic [31:0] hi;
		hi = next_rand32();
		return {hi, next_rand32()};
	endfunction

	function automatic logic [63:0] lane_mask(input int w);
		return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
	endfunction

	function automatic logic [31:0] ctrl_word(input alu_op_e op, input lane_w_e lw);
		return {22'd0, lw, 2'd0, op};
	endfunction

	// Expected result, lane 0 in the top bits
	function automatic logic [63:0] model_op(input alu_op_e op, input lane_w_e lw,
			input logic [63:0] a, input logic [63:0] b);
		int               w;
		int               lo;
		int               sh;
		logic [63:0]      mask;
		logic [63:0]      x;
		logic [63:0]      y;
		logic [63:0]      r;
		logic [63:0]      res;
		logic signed [63:0] sx;
		w = 8 << int'(lw);
		mask = lane_mask(w);
		res = '0;
		case (op)
			OP_AND: res = a & b;
			OP_OR:  res = a | b;
			OP_XOR: res = a ^ b;
			OP_NOT: res = ~a;
			OP_MOV: res = a;
			default: begin
				for (int i = 0; i < 64 / w; i++) begin
					lo = 64 - (i + 1) * w;
					x = (a >> lo) & mask;
					y = (b >> lo) & mask;
					sh = int'(y % 64'(w));
					sx = x << (64 - w);
					case (op)
						OP_ADD:  r = x + y;
						OP_SUB:  r = x - y;
						OP_SLL:  r = x << sh;
						OP_SRL:  r = x >> sh;
						OP_SRA:  r = sx >>> (64 - w + sh);
						OP_RTTH: r = (x << (w / 2)) | (x >> (w / 2));
						OP_DIV:  r = (y == 64'd0) ? mask : x / y;
						OP_MOD:  r = (y == 64'd0) ? x : x % y;
						default: r = '0;
					endcase
					res = res | ((r & mask) << lo);
				end
			end
		endcase
		return res;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		n_checks++;
		if (exp !== act) begin
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
			n_errors++;
		end
	endtask

	// Response signals in the access phase
	task automatic check_access(input logic exp_err);
		n_checks++;
		if (pslverr !== exp_err) begin
			$display("FAILED t=%0t pslverr expected %b got %b", $time, exp_err, pslverr);
			n_errors++;
		end
		n_checks++;
		if (pready !== 1'b1) begin
			$display("FAILED t=%0t pready expected 1 got %b", $time, pready);
			n_errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_access(exp_err);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		check_access(exp_err);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Poll STATUS until the given bit is set
	task automatic wait_status_bit(input int bit_idx);
		logic [31:0] st;
		logic        seen;
		int          polls;
		seen = 1'b0;
		polls = 0;
		while (!seen && polls < POLL_LIMIT) begin
			apb_read(REG_STATUS, 1'b0, st);
			seen = st[bit_idx];
			polls++;
		end
		if (!seen) begin
			$display("Timeout: STATUS bit %0d still clear after %0d polls at t=%0t",
				bit_idx, POLL_LIMIT, $time);
			n_errors++;
		end
	endtask

	task automatic read_result(output logic [63:0] res);
		logic [31:0] hi;
		logic [31:0] lo;
		apb_read(REG_RES_HI, 1'b0, hi);
		apb_read(REG_RES_LO, 1'b0, lo);
		res = {hi, lo};
	endtask

	task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
		apb_write(REG_A_HI, a[63:32], 1'b0);
		apb_write(REG_A_LO, a[31:0], 1'b0);
		apb_write(REG_B_HI, b[63:32], 1'b0);
		apb_write(REG_B_LO, b[31:0], 1'b0);
	endtask

	task automatic run_op(input alu_op_e op, input lane_w_e lw, input logic [63:0] a,
			input logic [63:0] b, output logic [63:0] res);
		load_operands(a, b);
		apb_write(REG_CTRL, ctrl_word(op, lw), 1'b0);
		wait_status_bit(1);
		read_result(res);
	endtask

	task automatic run_and_check(input alu_op_e op, input lane_w_e lw, input logic [63:0] a,
			input logic [63:0] b);
		logic [63:0] res;
		run_op(op, lw, a, b, res);
		check_value($sformatf("res %s w%0d", op.name(), 8 << int'(lw)), model_op(op, lw, a, b), res);
	endtask

	task automatic finish_test(input string name, input int err_start);
		n_tests++;
		if (n_errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, n_errors - err_start);
	endtask

	task automatic test_reset_regs();
		int          e0;
		logic [31:0] rd;
		logic [63:0] a;
		logic [63:0] b;
		e0 = n_errors;
		apb_read(REG_STATUS, 1'b0, rd);
		check_value("status", '0, {32'd0, rd});
		apb_read(REG_RES_HI, 1'b0, rd);
		check_value("res_hi", '0, {32'd0, rd});
		apb_read(REG_RES_LO, 1'b0, rd);
		check_value("res_lo", '0, {32'd0, rd});
		a = next_rand64();
		b = next_rand64();
		load_operands(a, b);
		apb_read(REG_A_HI, 1'b0, rd);
		check_value("a_hi", {32'd0, a[63:32]}, {32'd0, rd});
		apb_read(REG_A_LO, 1'b0, rd);
		check_value("a_lo", {32'd0, a[31:0]}, {32'd0, rd});
		apb_read(REG_B_HI, 1'b0, rd);
		check_value("b_hi", {32'd0, b[63:32]}, {32'd0, rd});
		apb_read(REG_B_LO, 1'b0, rd);
		check_value("b_lo", {32'd0, b[31:0]}, {32'd0, rd});
		apb_read(8'h20, 1'b1, rd);
		check_value("unmapped prdata", '0, {32'd0, rd});
		apb_read(8'hFC, 1'b1, rd);
		check_value("unmapped prdata", '0, {32'd0, rd});
		apb_write(REG_STATUS, 32'h3, 1'b1);
		apb_write(REG_RES_LO, 32'h1, 1'b1);
		finish_test("reset_regs", e0);
	endtask

	task automatic test_bitwise();
		int e0;
		e0 = n_errors;
		foreach (widths[l])
			foreach (bit_ops[k])
				run_and_check(bit_ops[k], widths[l], next_rand64(), next_rand64());
		finish_test("bitwise", e0);
	endtask

	task automatic test_arith();
		int e0;
		e0 = n_errors;
		foreach (widths[l]) begin
			run_and_check(OP_ADD, widths[l], next_rand64(), next_rand64());
			run_and_check(OP_SUB, widths[l], next_rand64(), next_rand64());
			// Every lane wraps at its own boundary
			run_and_check(OP_ADD, widths[l], '1, 64'h0101_0101_0101_0101);
			run_and_check(OP_SUB, widths[l], '0, 64'h0101_0101_0101_0101);
			run_and_check(OP_ADD, widths[l], 64'h7FFF_FFFF_80FF_FFFF, 64'h0001_0001_8001_0001);
		end
		finish_test("arith", e0);
	endtask

	task automatic test_shift_rotate();
		int e0;
		e0 = n_errors;
		foreach (widths[l]) begin
			foreach (sh_ops[k])
				run_and_check(sh_ops[k], widths[l], next_rand64(), next_rand64());
			run_and_check(OP_SRA, widths[l], 64'hF080_90A0_B0C0_D0E0, 64'h0102_0304_0506_0703);
			run_and_check(OP_SRA, widths[l], 64'h8000_0000_0000_0001, 64'h0000_0000_0000_003F);
		end
		finish_test("shift_rotate", e0);
	endtask

	task automatic test_div_mod();
		int          e0;
		int          w;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] mask;
		logic [63:0] res;
		e0 = n_errors;
		foreach (widths[l]) begin
			w = 8 << l;
			mask = lane_mask(w);
			run_and_check(OP_DIV, widths[l], next_rand64(), next_rand64());
			run_and_check(OP_MOD, widths[l], next_rand64(), next_rand64());
			a = next_rand64();
			b = next_rand64() & 64'h0F0F_0F0F_0F0F_0F0F;
			// Lane 0 gets divisor 0
			b = b & ~(mask << (64 - w));
			run_op(OP_DIV, widths[l], a, b, res);
			check_value("res div", model_op(OP_DIV, widths[l], a, b), res);
			check_value("lane0 quot", mask, (res >> (64 - w)) & mask);
			run_op(OP_MOD, widths[l], a, b, res);
			check_value("res mod", model_op(OP_MOD, widths[l], a, b), res);
			check_value("lane0 rem", (a >> (64 - w)) & mask, (res >> (64 - w)) & mask);
		end
		finish_test("div_mod", e0);
	endtask

	task automatic test_backpressure();
		int          e0;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic [63:0] res_before;
		logic [31:0] rd;
		e0 = n_errors;
		a = next_rand64();
		b = next_rand64() >> 20;
		load_operands(a, b);
		apb_write(REG_CTRL, ctrl_word(OP_DIV, W64), 1'b0);
		wait_status_bit(0);
		apb_write(REG_CTRL, ctrl_word(OP_ADD, W8), 1'b1);
		// Operand writes are allowed while busy
		apb_write(REG_A_LO, ~a[31:0], 1'b0);
		wait_status_bit(1);
		read_result(res);
		check_value("res div busy", model_op(OP_DIV, W64, a, b), res);
		res_before = res;
		apb_read(REG_STATUS, 1'b0, rd);
		check_value("status", 64'h2, {32'd0, rd});
		apb_write(REG_CTRL, 32'h0000_0008, 1'b1);
		repeat (4) @(posedge clk);
		apb_read(REG_STATUS, 1'b0, rd);
		check_value("status", 64'h2, {32'd0, rd});
		read_result(res);
		check_value("res", res_before, res);
		finish_test("backpressure", e0);
	endtask

	initial begin
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		n_errors = 0;
		n_checks = 0;
		n_tests = 0;
		lcg_state = 32'h28054361;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		test_reset_regs();
		test_bitwise();
		test_arith();
		test_shift_rotate();
		test_div_mod();
		test_backpressure();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* simd_alu_top.sv */
module simd_alu_top
	import simd_alu_pkg::*;
#(
	parameter int APB_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DW-1:0]     pwdata,
	output logic [APB_DW-1:0]     prdata,
	output logic                  pready,
	output logic                  pslverr
);

	logic              start;
	logic              busy;
	logic              done;
	logic              res_load;
	logic              div_load;
	logic              div_step;
	logic              cnt_load;
	logic              cnt_dec;
	logic              cnt_zero;
	alu_op_e           op;
	lane_w_e           lane_w;
	logic [DATA_W-1:0] opa;
	logic [DATA_W-1:0] opb;
	logic [DATA_W-1:0] alu_res;
	logic [DATA_W-1:0] quot;
	logic [DATA_W-1:0] rem;

	// No wait states
	assign pready = 1'b1;

	apb_regs #(
		.APB_ADDR_W(APB_ADDR_W)
	) i_apb_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pslverr (pslverr),
		.busy    (busy),
		.done    (done),
		.res_load(res_load),
		.alu_res (alu_res),
		.quot    (quot),
		.rem     (rem),
		.start   (start),
		.op      (op),
		.lane_w  (lane_w),
		.opa     (opa),
		.opb     (opb)
	);

	alu_ctrl_fsm i_alu_ctrl_fsm (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.op      (op),
		.cnt_zero(cnt_zero),
		.busy    (busy),
		.done    (done),
		.res_load(res_load),
		.div_load(div_load),
		.div_step(div_step),
		.cnt_load(cnt_load),
		.cnt_dec (cnt_dec)
	);

	div_step_counter i_div_step_counter (
		.clk     (clk),
		.arst_n  (arst_n),
		.cnt_load(cnt_load),
		.cnt_dec (cnt_dec),
		.lane_w  (lane_w),
		.cnt_zero(cnt_zero)
	);

	lane_alu i_lane_alu (
		.op     (op),
		.lane_w (lane_w),
		.opa    (opa),
		.opb    (opb),
		.alu_res(alu_res)
	);

	lane_divider i_lane_divider (
		.clk     (clk),
		.arst_n  (arst_n),
		.div_load(div_load),
		.div_step(div_step),
		.lane_w  (lane_w),
		.opa     (opa),
		.opb     (opb),
		.quot    (quot),
		.rem     (rem)
	);

endmodule

/* lane_divider.sv */
module lane_divider
	import simd_alu_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              div_load,
	input  logic              div_step,
	input  lane_w_e           lane_w,
	input  logic [DATA_W-1:0] opa,
	input  logic [DATA_W-1:0] opb,
	output logic [DATA_W-1:0] quot,
	output logic [DATA_W-1:0] rem
);

	logic [DATA_W-1:0]      rem_q;
	logic [DATA_W-1:0]      quo_q;
	logic [3:0][DATA_W-1:0] rem_nx;
	logic [3:0][DATA_W-1:0] quo_nx;

	for (genvar g = 0; g < 4; g++) begin : g_width
		localparam int W = 8 << g;

		for (genvar i = 0; i < DATA_W / W; i++) begin : g_lane
			localparam int LO = DATA_W - (i + 1) * W;

			logic [W:0]   rs;
			logic [W:0]   diff;
			logic [W-1:0] d;
			logic         ge;

			// Partial remainder needs one extra bit before the compare
			assign rs = {rem_q[LO +: W], quo_q[LO+W-1]};
			assign d = opb[LO +: W];
			assign diff = rs - {1'b0, d};
			assign ge = (rs >= {1'b0, d});

			// Divisor 0 always subtracts nothing, giving all ones and rem = dividend
			assign rem_nx[g][LO +: W] = ge ? diff[W-1:0] : rs[W-1:0];
			assign quo_nx[g][LO +: W] = {quo_q[LO +: W-1], ge};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rem_q <= '0;
			quo_q <= '0;
		end else if (div_load) begin
			rem_q <= '0;
			quo_q <= opa;
		end else if (div_step) begin
			rem_q <= rem_nx[lane_w];
			quo_q <= quo_nx[lane_w];
		end
	end

	assign quot = quo_q;
	assign rem = rem_q;

endmodule

/* lane_alu.sv */
module lane_alu
	import simd_alu_pkg::*;
(
	input  alu_op_e           op,
	input  lane_w_e           lane_w,
	input  logic [DATA_W-1:0] opa,
	input  logic [DATA_W-1:0] opb,
	output logic [DATA_W-1:0] alu_res
);

	// One result word per lane width
	logic [3:0][DATA_W-1:0] lane_res;

	for (genvar g = 0; g < 4; g++) begin : g_width
		localparam int W = 8 << g;
		localparam int SW = $clog2(W);

		for (genvar i = 0; i < DATA_W / W; i++) begin : g_lane
			// Lane 0 sits in the top bits
			localparam int LO = DATA_W - (i + 1) * W;

			logic [W-1:0]  a;
			logic [W-1:0]  b;
			logic [W-1:0]  r;
			logic [SW-1:0] sh;

			assign a = opa[LO +: W];
			assign b = opb[LO +: W];
			assign sh = b[SW-1:0];

			always_comb begin
				case (op)
					OP_ADD:  r = a + b;
					OP_SUB:  r = a - b;
					OP_SLL:  r = a << sh;
					OP_SRL:  r = a >> sh;
					OP_SRA:  r = $signed(a) >>> sh;
					OP_RTTH: r = {a[W/2-1:0], a[W-1:W/2]};
					default: r = a;
				endcase
			end

			assign lane_res[g][LO +: W] = r;
		end
	end

	// Bitwise ops ignore the lane width
	always_comb begin
		case (op)
			OP_AND:  alu_res = opa & opb;
			OP_OR:   alu_res = opa | opb;
			OP_XOR:  alu_res = opa ^ opb;
			OP_NOT:  alu_res = ~opa;
			OP_MOV:  alu_res = opa;
			default: alu_res = lane_res[lane_w];
		endcase
	end

endmodule

/* div_step_counter.sv */
module div_step_counter
	import simd_alu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    cnt_load,
	input  logic    cnt_dec,
	input  lane_w_e lane_w,
	output logic    cnt_zero
);

	logic [5:0] cnt;
	logic [5:0] cnt_init;

	// One step per lane bit
	always_comb begin
		case (lane_w)
			W8:      cnt_init = 6'd7;
			W16:     cnt_init = 6'd15;
			W32:     cnt_init = 6'd31;
			default: cnt_init = 6'd63;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cnt <= '0;
		else if (cnt_load)
			cnt <= cnt_init;
		else if (cnt_dec && !cnt_zero)
			cnt <= cnt - 6'd1;
	end

	assign cnt_zero = (cnt == 6'd0);

endmodule

/* alu_ctrl_fsm.sv */
module alu_ctrl_fsm
	import simd_alu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    start,
	input  alu_op_e op,
	input  logic    cnt_zero,
	output logic    busy,
	output logic    done,
	output logic    res_load,
	output logic    div_load,
	output logic    div_step,
	output logic    cnt_load,
	output logic    cnt_dec
);

	ctrl_state_e state;
	ctrl_state_e state_nx;
	logic        is_div;

	assign is_div = (op == OP_DIV) || (op == OP_MOD);

	always_comb begin
		state_nx = state;
		div_load = 1'b0;
		cnt_load = 1'b0;
		case (state)
			S_IDLE, S_DONE: begin
				if (start) begin
					if (is_div) begin
						state_nx = S_DIV;
						div_load = 1'b1;
						cnt_load = 1'b1;
					end else begin
						state_nx = S_EXEC;
					end
				end
			end
			// Last divide step, then write back through S_EXEC
			S_DIV:   if (cnt_zero) state_nx = S_EXEC;
			S_EXEC:  state_nx = S_DONE;
			default: state_nx = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= S_IDLE;
		else
			state <= state_nx;
	end

	assign div_step = (state == S_DIV);
	assign cnt_dec = (state == S_DIV);
	assign res_load = (state == S_EXEC);
	assign busy = (state == S_EXEC) || (state == S_DIV);
	assign done = (state == S_DONE);

endmodule

/* apb_regs.sv */
module apb_regs
	import simd_alu_pkg::*;
#(
	parameter int APB_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DW-1:0]     pwdata,
	output logic [APB_DW-1:0]     prdata,
	output logic                  pslverr,
	input  logic                  busy,
	input  logic                  done,
	input  logic                  res_load,
	input  logic [DATA_W-1:0]     alu_res,
	input  logic [DATA_W-1:0]     quot,
	input  logic [DATA_W-1:0]     rem,
	output logic                  start,
	output alu_op_e               op,
	output lane_w_e               lane_w,
	output logic [DATA_W-1:0]     opa,
	output logic [DATA_W-1:0]     opb
);

	logic [7:0]        addr;
	logic              acc;
	logic              wr;
	logic              ctrl_wr;
	logic              ctrl_ok;
	logic              op_ok;
	logic              mapped;
	logic              ro;
	logic [DATA_W-1:0] a_q;
	logic [DATA_W-1:0] b_q;
	logic [DATA_W-1:0] res_q;
	logic [DATA_W-1:0] res_nx;

	assign addr = 8'(paddr);
	assign acc = psel & penable;
	assign wr = acc & pwrite;
	assign ctrl_wr = wr && (addr == REG_CTRL);
	assign op_ok = pwdata[5:0] inside {[OP_AND:OP_SUB], [OP_SLL:OP_MOD]};

	// A pending start counts as busy too
	assign ctrl_ok = ctrl_wr && !busy && !start && op_ok;

	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		ro = 1'b0;
		case (addr)
			REG_A_HI:   prdata = a_q[63:32];
			REG_A_LO:   prdata = a_q[31:0];
			REG_B_HI:   prdata = b_q[63:32];
			REG_B_LO:   prdata = b_q[31:0];
			REG_CTRL:   prdata = {22'd0, lane_w, 2'd0, op};
			REG_STATUS: begin
				prdata = {30'd0, done, busy};
				ro = 1'b1;
			end
			REG_RES_HI: begin
				prdata = res_q[63:32];
				ro = 1'b1;
			end
			REG_RES_LO: begin
				prdata = res_q[31:0];
				ro = 1'b1;
			end
			default:    mapped = 1'b0;
		endcase
	end

	assign pslverr = acc && (!mapped || (pwrite && ro) || (ctrl_wr && !ctrl_ok));

	always_comb begin
		case (op)
			OP_DIV:  res_nx = quot;
			OP_MOD:  res_nx = rem;
			default: res_nx = alu_res;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a_q <= '0;
			b_q <= '0;
			opa <= '0;
			opb <= '0;
			op <= alu_op_e'('0);
			lane_w <= W8;
			start <= 1'b0;
			res_q <= '0;
		end else begin
			if (wr) begin
				case (addr)
					REG_A_HI: a_q[63:32] <= pwdata;
					REG_A_LO: a_q[31:0] <= pwdata;
					REG_B_HI: b_q[63:32] <= pwdata;
					REG_B_LO: b_q[31:0] <= pwdata;
					default: ;
				endcase
			end
			// Snapshot operands so later writes do not disturb the op in flight
			if (ctrl_ok) begin
				op <= alu_op_e'(pwdata[5:0]);
				lane_w <= lane_w_e'(pwdata[9:8]);
				opa <= a_q;
				opb <= b_q;
			end
			start <= ctrl_ok;
			if (res_load)
				res_q <= res_nx;
		end
	end

endmodule

/* simd_alu_pkg.sv */
package simd_alu_pkg;

	localparam int DATA_W = 64;
	localparam int APB_DW = 32;

	// Vector opcodes, reference encodings
	typedef enum logic [5:0] {
		OP_AND  = 6'd1,
		OP_OR   = 6'd2,
		OP_XOR  = 6'd3,
		OP_NOT  = 6'd4,
		OP_MOV  = 6'd5,
		OP_ADD  = 6'd6,
		OP_SUB  = 6'd7,
		OP_SLL  = 6'd10,
		OP_SRL  = 6'd11,
		OP_SRA  = 6'd12,
		OP_RTTH = 6'd13,
		OP_DIV  = 6'd14,
		OP_MOD  = 6'd15
	} alu_op_e;

	typedef enum logic [1:0] {
		W8  = 2'd0,
		W16 = 2'd1,
		W32 = 2'd2,
		W64 = 2'd3
	} lane_w_e;

	typedef enum logic [1:0] {
		S_IDLE,
		S_EXEC,
		S_DIV,
		S_DONE
	} ctrl_state_e;

	// Register byte offsets
	localparam logic [7:0] REG_A_HI   = 8'h00;
	localparam logic [7:0] REG_A_LO   = 8'h04;
	localparam logic [7:0] REG_B_HI   = 8'h08;
	localparam logic [7:0] REG_B_LO   = 8'h0C;
	localparam logic [7:0] REG_CTRL   = 8'h10;
	localparam logic [7:0] REG_STATUS = 8'h14;
	localparam logic [7:0] REG_RES_HI = 8'h18;
	localparam logic [7:0] REG_RES_LO = 8'h1C;

endpackage
